//--- clct_pkg.sv
`default_nettype none

package clct_pkg;

  // --------------------------------------------------------------------------
  // chamber format widths
  // --------------------------------------------------------------------------

  // key half-strip groups per chamber
  localparam int NGRP    = 7;
  // pattern word
  localparam int MXPATB  = 7;
  // key half-strip inside one group
  localparam int MXKEYB  = 5;
  // extended key with group index on top
  localparam int MXKEYBX = 8;
  // comparator-code fit offset
  localparam int MXOFFSB = 4;
  // fit quality, also the sort key width
  localparam int MXQLTB  = 6;
  localparam int MXBNDB  = 5;
  // comparator-code carry
  localparam int MXPATC  = 12;
  // quarter-strip subkey
  localparam int MXXKYB  = 10;

  // --------------------------------------------------------------------------
  // timing and selection
  // --------------------------------------------------------------------------

  localparam int TIMER_W = 2;
  // window length in cycles starting at the pretrigger
  localparam logic [TIMER_W-1:0] DRIFT_CYCLES = 2'd3;
  // hold-off after the trigger word goes out
  localparam logic [TIMER_W-1:0] DEAD_CYCLES  = 2'd2;
  // minimum layers hit for a valid trigger
  localparam logic [2:0] HIT_THRESH = 3'd4;
  // set to sort on fit quality instead of the pattern number
  localparam bit SORT_ON_QLT = 1'b0;

  // sequencer state codes
  localparam logic [1:0] S_IDLE   = 2'd0;
  localparam logic [1:0] S_DRIFT  = 2'd1;
  localparam logic [1:0] S_SELECT = 2'd2;
  localparam logic [1:0] S_DEAD   = 2'd3;

  // one pattern word seen two ways
  // lsb of the pattern number gives the bend direction and is left out of the sort
  typedef union packed {
    struct packed {
      logic [2:0] nhit;
      logic [3:0] pid;
    } hit_view;
    struct packed {
      logic [5:0] key;
      logic       bend_dir;
    } sort_view;
  } pat_word_t;

  // sort key of one candidate
  function automatic logic [MXQLTB-1:0] sort_key_f(input pat_word_t pat,
                                                   input logic [MXQLTB-1:0] qlt);
    sort_key_f = SORT_ON_QLT ? qlt : pat.sort_view.key;
  endfunction

endpackage

`default_nettype wire

//--- clct_cand_if.sv
`default_nettype none

interface clct_cand_if (input logic clock);
  import clct_pkg::*;

  // one candidate per key group
  pat_word_t            pat   [NGRP];
  logic [MXKEYB-1:0]    key   [NGRP];
  logic [MXOFFSB-1:0]   offs  [NGRP];
  logic [MXQLTB-1:0]    qlt   [NGRP];
  logic [MXBNDB-1:0]    bend  [NGRP];
  logic [MXPATC-1:0]    carry [NGRP];

  // the side that fills the candidate set
  modport producer
  (
    input  clock,
    output pat, key, offs, qlt, bend, carry
  );

  // the side that reads it
  modport consumer
  (
    input  clock,
    input  pat, key, offs, qlt, bend, carry
  );

endinterface

`default_nettype wire

//--- drift_timer.sv
`default_nettype none

module drift_timer
(
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          timer_load,
  input  logic [clct_pkg::TIMER_W-1:0]  timer_count,
  output logic                          timer_done,
  output logic                          running
);
  import clct_pkg::*;

  logic [TIMER_W-1:0] cnt;

  // load N-1 so the done pulse lands N cycles after the load
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      cnt     <= '0;
      running <= 1'b0;
    end
    else if (timer_load)
    begin
      cnt     <= timer_count - 2'd1;
      running <= 1'b1;
    end
    else if (running)
    begin
      // stop on the expiry cycle
      if (cnt == '0)
        running <= 1'b0;
      else
        cnt <= cnt - 2'd1;
    end
  end

  assign timer_done = running && (cnt == '0);

  // a reload would cut the window short
  a_no_load_running: assert property (@(posedge clock) disable iff (reset)
    running |-> !timer_load);

endmodule

`default_nettype wire

//--- clct_sequencer.sv
`default_nettype none

module clct_sequencer
(
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          pretrig,
  input  logic                          timer_done,
  output logic                          timer_load,
  output logic [clct_pkg::TIMER_W-1:0]  timer_count,
  output logic                          acc_clear,
  output logic                          acc_enable,
  output logic                          out_load,
  output logic                          busy
);
  import clct_pkg::*;

  logic [1:0] state;
  logic [1:0] state_next;

  // --------------------------------------------------------------------------
  // state register
  // --------------------------------------------------------------------------

  always_comb
  begin
    state_next = state;
    case (state)
      // pretrig outside idle is dropped
      S_IDLE:   if (pretrig) state_next = S_DRIFT;
      S_DRIFT:  if (timer_done) state_next = S_SELECT;
      // single cycle to start the dead time
      S_SELECT: state_next = S_DEAD;
      S_DEAD:   if (timer_done) state_next = S_IDLE;
      default:  state_next = S_IDLE;
    endcase
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      state <= S_IDLE;
    else
      state <= state_next;
  end

  // --------------------------------------------------------------------------
  // control strobes
  // --------------------------------------------------------------------------

  // first window cycle takes the inputs as they are
  assign acc_clear   = (state == S_IDLE) && pretrig;
  // fold in until the window expires
  assign acc_enable  = (state == S_DRIFT) && !timer_done;
  // accumulator is final on the expiry cycle
  assign out_load    = (state == S_DRIFT) && timer_done;

  // same timer for window and dead time
  assign timer_load  = acc_clear || (state == S_SELECT);
  assign timer_count = (state == S_SELECT) ? DEAD_CYCLES : DRIFT_CYCLES;

  assign busy = (state != S_IDLE);

  // trigger word goes out once per window
  a_out_load_pulse: assert property (@(posedge clock) disable iff (reset)
    out_load |=> !out_load);

  // trigger word follows the accepted pretrig by the window length
  a_window_length: assert property (@(posedge clock) disable iff (reset)
    out_load |-> $past(acc_clear, DRIFT_CYCLES));

endmodule

`default_nettype wire

//--- cand_accumulator.sv
`default_nettype none

module cand_accumulator
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  acc_clear,
  input  logic                  acc_enable,
  clct_cand_if.consumer         cands_in,
  clct_cand_if.producer         cands_out
);
  import clct_pkg::*;

  logic [NGRP-1:0] take;

  // per group replace only on a strictly better sort key
  // equal keys keep the earlier candidate
  always_comb
  begin
    for (int g = 0; g < NGRP; g++)
    begin
      take[g] = acc_clear ||
                (acc_enable &&
                 (sort_key_f(cands_in.pat[g], cands_in.qlt[g]) >
                  sort_key_f(cands_out.pat[g], cands_out.qlt[g])));
    end
  end

  // stored best candidate per group
  always_ff @(posedge clock)
  begin
    for (int g = 0; g < NGRP; g++)
    begin
      if (reset)
      begin
        // only the fields that feed the sort are cleared
        cands_out.pat[g] <= '0;
        cands_out.qlt[g] <= '0;
      end
      else if (take[g])
      begin
        cands_out.pat[g]   <= cands_in.pat[g];
        cands_out.key[g]   <= cands_in.key[g];
        cands_out.offs[g]  <= cands_in.offs[g];
        cands_out.qlt[g]   <= cands_in.qlt[g];
        cands_out.bend[g]  <= cands_in.bend[g];
        cands_out.carry[g] <= cands_in.carry[g];
      end
    end
  end

endmodule

`default_nettype wire

//--- best_1of7_cclut.sv
`default_nettype none

module best_1of7_cclut
(
  clct_cand_if.consumer                 cands,
  output clct_pkg::pat_word_t           best_pat,
  output logic [clct_pkg::MXKEYBX-1:0]  best_key,
  output logic [clct_pkg::MXBNDB-1:0]   best_bend,
  output logic [clct_pkg::MXPATC-1:0]   best_carry,
  output logic [clct_pkg::MXXKYB-1:0]   best_subkey,
  output logic [clct_pkg::MXQLTB-1:0]   best_qlt
);
  import clct_pkg::*;

  logic [MXQLTB-1:0]          sort_key [NGRP];
  logic [MXKEYBX-MXKEYB-1:0]  best_grp;
  logic [MXQLTB-1:0]          best_srt;
  logic [MXOFFSB-1:0]         best_offs;
  logic [MXKEYB-1:0]          grp_key;
  logic [1:0]                 sub_lsb;
  logic                       in_known;

  // --------------------------------------------------------------------------
  // best 1 of 7
  // --------------------------------------------------------------------------

  // sort on quality or on the pattern number without its lsb
  always_comb
  begin
    for (int g = 0; g < NGRP; g++)
    begin
      sort_key[g] = sort_key_f(cands.pat[g], cands.qlt[g]);
    end
  end

  // scan upward and move only on strictly greater
  // so a tie stays with the lower group
  always_comb
  begin
    best_grp = '0;
    best_srt = sort_key[0];
    for (int g = 1; g < NGRP; g++)
    begin
      if (sort_key[g] > best_srt)
      begin
        best_grp = (MXKEYBX-MXKEYB)'(g);
        best_srt = sort_key[g];
      end
    end
  end

  // winner fields
  assign best_pat   = cands.pat[best_grp];
  assign best_qlt   = cands.qlt[best_grp];
  assign best_bend  = cands.bend[best_grp];
  assign best_carry = cands.carry[best_grp];
  assign best_offs  = cands.offs[best_grp];
  assign grp_key    = cands.key[best_grp];

  // --------------------------------------------------------------------------
  // extended key and subkey
  // --------------------------------------------------------------------------

  // group index above the key
  // then upper offset bits plus and of the low pair minus 2
  // wraps mod 256 at the chamber edge
  assign best_key = {best_grp, grp_key}
                  + MXKEYBX'(best_offs[3:2])
                  + MXKEYBX'(best_offs[1] & best_offs[0])
                  - MXKEYBX'(2);

  // quarter-strip bits from the low offset pair
  assign sub_lsb     = best_offs[1:0] + 2'd1;
  assign best_subkey = {best_key, sub_lsb};

  // all seven candidates fully known
  always_comb
  begin
    in_known = 1'b1;
    for (int g = 0; g < NGRP; g++)
    begin
      if ($isunknown({cands.pat[g], cands.key[g], cands.offs[g],
                      cands.qlt[g], cands.bend[g], cands.carry[g]}))
        in_known = 1'b0;
    end
  end

  a_out_known: assert property (@(posedge cands.clock)
    in_known |-> !$isunknown({best_pat, best_key, best_bend, best_carry,
                              best_subkey, best_qlt}));

endmodule

`default_nettype wire

//--- clct_output.sv
`default_nettype none

module clct_output
(
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          out_load,
  input  clct_pkg::pat_word_t           best_pat,
  input  logic [clct_pkg::MXKEYBX-1:0]  best_key,
  input  logic [clct_pkg::MXBNDB-1:0]   best_bend,
  input  logic [clct_pkg::MXPATC-1:0]   best_carry,
  input  logic [clct_pkg::MXXKYB-1:0]   best_subkey,
  input  logic [clct_pkg::MXQLTB-1:0]   best_qlt,
  output logic                          clct_strobe,
  output logic                          clct_valid,
  output clct_pkg::pat_word_t           clct_pat,
  output logic [clct_pkg::MXKEYBX-1:0]  clct_key,
  output logic [clct_pkg::MXBNDB-1:0]   clct_bend,
  output logic [clct_pkg::MXPATC-1:0]   clct_carry,
  output logic [clct_pkg::MXXKYB-1:0]   clct_subkey,
  output logic [clct_pkg::MXQLTB-1:0]   clct_qlt
);
  import clct_pkg::*;

  logic pass_thresh;

  // layer count from the hit view of the pattern word
  assign pass_thresh = (best_pat.hit_view.nhit >= HIT_THRESH);

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      clct_strobe <= 1'b0;
      clct_valid  <= 1'b0;
      clct_pat    <= '0;
      clct_key    <= '0;
      clct_bend   <= '0;
      clct_carry  <= '0;
      clct_subkey <= '0;
      clct_qlt    <= '0;
    end
    else
    begin
      // strobe and valid last one cycle
      clct_strobe <= out_load;
      clct_valid  <= out_load && pass_thresh;
      // fields held until the next trigger
      // still reported below threshold
      if (out_load)
      begin
        clct_pat    <= best_pat;
        clct_key    <= best_key;
        clct_bend   <= best_bend;
        clct_carry  <= best_carry;
        clct_subkey <= best_subkey;
        clct_qlt    <= best_qlt;
      end
    end
  end

endmodule

`default_nettype wire

//--- clct_finder_top.sv
`default_nettype none

module clct_finder_top
(
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          pretrig,
  input  logic [clct_pkg::MXPATB-1:0]   pat_in   [clct_pkg::NGRP],
  input  logic [clct_pkg::MXKEYB-1:0]   key_in   [clct_pkg::NGRP],
  input  logic [clct_pkg::MXOFFSB-1:0]  offs_in  [clct_pkg::NGRP],
  input  logic [clct_pkg::MXQLTB-1:0]   qlt_in   [clct_pkg::NGRP],
  input  logic [clct_pkg::MXBNDB-1:0]   bend_in  [clct_pkg::NGRP],
  input  logic [clct_pkg::MXPATC-1:0]   carry_in [clct_pkg::NGRP],
  output logic                          clct_strobe,
  output logic                          clct_valid,
  output logic                          busy,
  output clct_pkg::pat_word_t           clct_pat,
  output logic [clct_pkg::MXKEYBX-1:0]  clct_key,
  output logic [clct_pkg::MXBNDB-1:0]   clct_bend,
  output logic [clct_pkg::MXPATC-1:0]   clct_carry,
  output logic [clct_pkg::MXXKYB-1:0]   clct_subkey,
  output logic [clct_pkg::MXQLTB-1:0]   clct_qlt
);
  import clct_pkg::*;

  logic                 timer_load;
  logic [TIMER_W-1:0]   timer_count;
  logic                 timer_done;
  logic                 acc_clear;
  logic                 acc_enable;
  logic                 out_load;
  pat_word_t            best_pat;
  logic [MXKEYBX-1:0]   best_key;
  logic [MXBNDB-1:0]    best_bend;
  logic [MXPATC-1:0]    best_carry;
  logic [MXXKYB-1:0]    best_subkey;
  logic [MXQLTB-1:0]    best_qlt;

  clct_cand_if in_cands  (.clock(clock));
  clct_cand_if acc_cands (.clock(clock));

  // raw group ports into the candidate bundle
  for (genvar g = 0; g < NGRP; g++)
  begin : g_pack
    assign in_cands.pat[g]   = pat_in[g];
    assign in_cands.key[g]   = key_in[g];
    assign in_cands.offs[g]  = offs_in[g];
    assign in_cands.qlt[g]   = qlt_in[g];
    assign in_cands.bend[g]  = bend_in[g];
    assign in_cands.carry[g] = carry_in[g];
  end

  clct_sequencer u_seq (
    .clock, .reset, .pretrig, .timer_done, .timer_load, .timer_count,
    .acc_clear, .acc_enable, .out_load, .busy);

  // running only feeds the timer's own check
  drift_timer u_timer (
    .clock, .reset, .timer_load, .timer_count, .timer_done, .running());

  cand_accumulator u_acc (
    .clock, .reset, .acc_clear, .acc_enable,
    .cands_in(in_cands), .cands_out(acc_cands));

  best_1of7_cclut u_best (
    .cands(acc_cands), .best_pat, .best_key, .best_bend, .best_carry,
    .best_subkey, .best_qlt);

  clct_output u_out (
    .clock, .reset, .out_load, .best_pat, .best_key, .best_bend, .best_carry,
    .best_subkey, .best_qlt, .clct_strobe, .clct_valid, .clct_pat, .clct_key,
    .clct_bend, .clct_carry, .clct_subkey, .clct_qlt);

endmodule

`default_nettype wire

//--- tb_clct_finder.sv
`default_nettype none

module tb_clct_finder;
  import clct_pkg::*;

  // trace capacity and event timing in cycles from the pretrigger
  localparam int MAXEV     = 16;
  localparam int STROBE_AT = 4;
  localparam int LAST_BUSY = 4 + DEAD_CYCLES;

  logic                 clock;
  logic                 reset;
  logic                 pretrig;
  logic [MXPATB-1:0]    pat_in   [NGRP];
  logic [MXKEYB-1:0]    key_in   [NGRP];
  logic [MXOFFSB-1:0]   offs_in  [NGRP];
  logic [MXQLTB-1:0]    qlt_in   [NGRP];
  logic [MXBNDB-1:0]    bend_in  [NGRP];
  logic [MXPATC-1:0]    carry_in [NGRP];
  logic                 clct_strobe;
  logic                 clct_valid;
  logic                 busy;
  pat_word_t            clct_pat;
  logic [MXKEYBX-1:0]   clct_key;
  logic [MXBNDB-1:0]    clct_bend;
  logic [MXPATC-1:0]    clct_carry;
  logic [MXXKYB-1:0]    clct_subkey;
  logic [MXQLTB-1:0]    clct_qlt;

  // trace candidates per event, window cycle and group
  bit                   cset  [MAXEV][4][NGRP];
  logic [MXPATB-1:0]    cpat  [MAXEV][4][NGRP];
  logic [MXKEYB-1:0]    ckey  [MAXEV][4][NGRP];
  logic [MXOFFSB-1:0]   coffs [MAXEV][4][NGRP];
  logic [MXQLTB-1:0]    cqlt  [MAXEV][4][NGRP];
  // extra pretrig cycle, 0 for none
  int                   xpre  [MAXEV];
  // expected key, subkey, pat, qlt, valid
  logic [31:0]          exp_res [MAXEV][5];
  // bend and carry driven in the current window per cycle and group
  logic [MXBNDB-1:0]    dbend  [4][NGRP];
  logic [MXPATC-1:0]    dcarry [4][NGRP];

  int nev;
  int errors;
  int checks;
  int cycles;
  int limit;

  clct_finder_top u_clct_finder_top (
    .clock, .reset, .pretrig, .pat_in, .key_in, .offs_in, .qlt_in, .bend_in,
    .carry_in, .clct_strobe, .clct_valid, .busy, .clct_pat, .clct_key,
    .clct_bend, .clct_carry, .clct_subkey, .clct_qlt);

  initial
  begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // ------------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------------

  task automatic compare_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    checks++;
    if (exp_v !== act_v)
    begin
      errors++;
      $display("Error: %s expected %0h actual %0h", name, exp_v, act_v);
    end
  endtask

  task automatic read_trace();
    int fd;
    int ch;
    int a0, a1, a2, a3, a4, a5;
    logic [7:0] tag;
    fd = $fopen("clct_trace.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open trace file clct_trace.txt");
      errors++;
      return;
    end
    while ($fscanf(fd, "%s", tag) == 1)
    begin
      if (tag == "#")
      begin
        // skip the rest of a comment line
        ch = 0;
        while (ch != 10 && ch != -1)
          ch = $fgetc(fd);
      end
      else if (tag == "C")
      begin
        void'($fscanf(fd, "%h %h %h %h %h %h", a0, a1, a2, a3, a4, a5));
        cset[nev][a0][a1]  = 1'b1;
        cpat[nev][a0][a1]  = MXPATB'(a2);
        ckey[nev][a0][a1]  = MXKEYB'(a3);
        coffs[nev][a0][a1] = MXOFFSB'(a4);
        cqlt[nev][a0][a1]  = MXQLTB'(a5);
      end
      else if (tag == "E")
      begin
        void'($fscanf(fd, "%h %h %h %h %h %h", a0, a1, a2, a3, a4, a5));
        xpre[nev]       = a0;
        exp_res[nev][0] = a1;
        exp_res[nev][1] = a2;
        exp_res[nev][2] = a3;
        exp_res[nev][3] = a4;
        exp_res[nev][4] = a5;
        nev++;
      end
    end
    $fclose(fd);
    if (nev == 0)
    begin
      $display("trace file holds no events");
      errors++;
    end
  endtask

  // one cycle of candidates, trace entries over a low random fill
  task automatic drive_cycle(input int e, input int c);
    logic [MXBNDB-1:0] bnd;
    logic [MXPATC-1:0] cry;
    for (int g = 0; g < NGRP; g++)
    begin
      if (c < 4 && cset[e][c][g])
      begin
        pat_in[g]  <= cpat[e][c][g];
        key_in[g]  <= ckey[e][c][g];
        offs_in[g] <= coffs[e][c][g];
        qlt_in[g]  <= cqlt[e][c][g];
      end
      else
      begin
        // pattern below 8 keeps the sort key under any trace entry
        pat_in[g]  <= MXPATB'($urandom % 8);
        key_in[g]  <= MXKEYB'($urandom);
        offs_in[g] <= MXOFFSB'($urandom);
        qlt_in[g]  <= MXQLTB'($urandom);
      end
      bnd = MXBNDB'($urandom);
      cry = MXPATC'($urandom);
      bend_in[g]  <= bnd;
      carry_in[g] <= cry;
      if (c < 4)
      begin
        dbend[c][g]  = bnd;
        dcarry[c][g] = cry;
      end
    end
    pretrig <= (c == 0) || (xpre[e] != 0 && c == xpre[e]);
  endtask

  // window cycle and group of the trace entry named by the expected pat and qlt
  // the earliest cycle wins, -1 when none matches
  task automatic find_winner(input int e, output int wc, output int wg);
    wc = -1;
    wg = -1;
    for (int c = 0; c < 3; c++)
    begin
      for (int g = 0; g < NGRP; g++)
      begin
        if (wc < 0 && cset[e][c][g] &&
            32'(cpat[e][c][g]) == exp_res[e][2] &&
            32'(cqlt[e][c][g]) == exp_res[e][3])
        begin
          wc = c;
          wg = g;
        end
      end
    end
  endtask

  // ------------------------------------------------------------------------
  // watchdog on the cycle count
  // ------------------------------------------------------------------------

  always @(posedge clock)
  begin
    if (!reset)
    begin
      cycles = cycles + 1;
      if (cycles > limit)
      begin
        $display("timeout waiting for clct strobe");
        $display("checks %0d, errors %0d", checks, errors + 1);
        $display("*** TEST FAILED ***");
        $finish;
      end
    end
  end

  initial
  begin
    string tname;
    int c;
    int wc;
    int wg;
    bit seen;
    void'($urandom(31));
    errors = 0;
    checks = 0;
    cycles = 0;
    nev = 0;
    reset = 1'b1;
    pretrig = 1'b0;
    for (int g = 0; g < NGRP; g++)
    begin
      pat_in[g]   = '0;
      key_in[g]   = '0;
      offs_in[g]  = '0;
      qlt_in[g]   = '0;
      bend_in[g]  = '0;
      carry_in[g] = '0;
    end
    read_trace();
    limit = nev * (4 + DEAD_CYCLES + 4) + 50;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    compare_value("after reset busy", 0, 32'(busy));
    compare_value("after reset strobe", 0, 32'(clct_strobe));
    compare_value("after reset key", 0, 32'(clct_key));

    // each event starts on the first idle cycle after the previous one
    for (int e = 0; e < nev; e++)
    begin
      c = 0;
      seen = 1'b0;
      while (!seen || c <= LAST_BUSY)
      begin
        @(posedge clock);
        drive_cycle(e, c);
        @(negedge clock);
        tname = $sformatf("event %0d cycle %0d", e + 1, c);
        compare_value({tname, " strobe"}, 32'(c == STROBE_AT), 32'(clct_strobe));
        compare_value({tname, " busy"}, 32'(c >= 1 && c <= LAST_BUSY), 32'(busy));
        if (clct_strobe && !seen)
        begin
          seen = 1'b1;
          compare_value({tname, " key"}, exp_res[e][0], 32'(clct_key));
          compare_value({tname, " subkey"}, exp_res[e][1], 32'(clct_subkey));
          compare_value({tname, " pat"}, exp_res[e][2], 32'(clct_pat));
          compare_value({tname, " qlt"}, exp_res[e][3], 32'(clct_qlt));
          compare_value({tname, " valid"}, exp_res[e][4], 32'(clct_valid));
          // bend and carry travel with the winning candidate
          find_winner(e, wc, wg);
          if (wc < 0)
          begin
            $display("trace event %0d names no candidate inside its window", e + 1);
            errors++;
          end
          else
          begin
            compare_value({tname, " bend"}, 32'(dbend[wc][wg]), 32'(clct_bend));
            compare_value({tname, " carry"}, 32'(dcarry[wc][wg]), 32'(clct_carry));
          end
        end
        c++;
      end
    end

    // nothing may still be pending
    repeat (8)
    begin
      @(posedge clock);
      pretrig <= 1'b0;
      @(negedge clock);
      compare_value("tail strobe", 0, 32'(clct_strobe));
      compare_value("tail busy", 0, 32'(busy));
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- clct_trace.txt
# C cycle group pat key offs qlt    candidate in window cycle 0 to 2, cycle 3 is one past the window
# E xpre key subkey pat qlt valid   expected result, xpre is an extra pretrig cycle or 0, all hex
C 0 3 4c 0a 6 14
E 0 69 1a7 4c 14 1
C 0 2 5a 04 3 11
C 0 5 5b 1c 0 3f
E 0 43 10c 5a 11 1
C 0 0 70 00 0 2a
E 0 fe 3f9 70 2a 1
C 0 4 44 01 0 05
C 1 1 50 0c 2 22
C 2 4 66 1f f 30
E 0 a1 284 66 30 1
C 0 6 48 02 8 07
C 3 1 7e 10 4 3d
E 0 c2 309 48 07 1
C 1 5 3e 15 5 1c
E 0 b4 2d2 3e 1c 0
C 0 1 60 08 1 09
E 2 26 09a 60 09 1
C 0 0 4a 1e c 3b
E 6 1f 07d 4a 3b 1
C 0 3 52 05 2 01
C 1 3 53 07 1 02
E 0 63 18f 52 01 1

//--- project.f
clct_pkg.sv
clct_cand_if.sv
drift_timer.sv
clct_sequencer.sv
cand_accumulator.sv
best_1of7_cclut.sv
clct_output.sv
clct_finder_top.sv
tb_clct_finder.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_clct_finder
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
